// ==== all.f ====
+incdir+.
sap_pkg.sv
sap_prog_port.sv
sap_control.sv
sap_datapath.sv
sap_output.sv
sap_top.sv
sap_sva.sv
tb_sap.sv

// ==== run.sh ====
#!/bin/sh
# Build the SAP testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_sap

./obj_dir/Vtb_sap > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
echo "Simulation passed"

// ==== sap_control.sv ====
// ---------------------------------------------------------------------------
// SAP micro-sequencer
// Steps each instruction through stages T0..T5 on the rising edge and
// decodes the control word on the falling edge, so the datapath acts on
// the next rising edge. Also runs the byte-loading passes of programming
// ---------------------------------------------------------------------------
`default_nettype none

module sap_control (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire sap_pkg::opcode_t  opcode,
    input  wire logic              prog_sync,
    output sap_pkg::ctrl_t         ctrl,
    output logic                   read_ui_in,
    output logic                   done_load,
    output logic                   ready,
    output logic                   halted
);

    sap_pkg::stage_t stage;
    logic            halt_flag;
    sap_pkg::ctrl_t  ctrl_next;
    logic            read_next;
    logic            done_next;
    logic            ready_next;

    // Stage counter and halt flag
    always_ff @(posedge clk) begin
        if (!resetn) begin
            stage     <= sap_pkg::IDLE;
            halt_flag <= 1'b0;
        end else begin
            if (stage == sap_pkg::T3 && !prog_sync && opcode == sap_pkg::OP_HLT)
                halt_flag <= 1'b1;
            if (halt_flag) begin
                stage <= sap_pkg::HALT;
            end else begin
                case (stage)
                    sap_pkg::IDLE: stage <= sap_pkg::T0;
                    sap_pkg::T0:   stage <= sap_pkg::T1;
                    sap_pkg::T1:   stage <= sap_pkg::T2;
                    sap_pkg::T2:   stage <= sap_pkg::T3;
                    sap_pkg::T3:   stage <= sap_pkg::T4;
                    sap_pkg::T4:   stage <= sap_pkg::T5;
                    sap_pkg::T5:   stage <= sap_pkg::IDLE;
                    default:       stage <= sap_pkg::HALT;
                endcase
            end
        end
    end

    assign halted = halt_flag;

    // Micro-operation table
    always_comb begin
        ctrl_next  = sap_pkg::CTRL_IDLE;
        read_next  = 1'b0;
        done_next  = 1'b0;
        ready_next = 1'b0;
        case (stage)
            sap_pkg::T0: begin
                ctrl_next.pc_en           = 1'b1;   // MAR <= PC
                ctrl_next.mar_addr_load_n = 1'b0;
                ready_next                = 1'b1;
            end
            sap_pkg::T1: ctrl_next.pc_inc = 1'b1;
            sap_pkg::T2: begin
                if (!prog_sync) begin
                    ctrl_next.ram_en_n  = 1'b0;     // IR <= RAM[MAR]
                    ctrl_next.ir_load_n = 1'b0;
                end
            end
            sap_pkg::T3: begin
                if (prog_sync) begin
                    read_next                = 1'b1;   // MDR <= input byte
                    ctrl_next.mar_mem_load_n = 1'b0;
                end else begin
                    case (opcode)
                        sap_pkg::OP_ADD, sap_pkg::OP_SUB, sap_pkg::OP_LDA,
                        sap_pkg::OP_STA: begin
                            ctrl_next.ir_en_n         = 1'b0;   // MAR <= operand
                            ctrl_next.mar_addr_load_n = 1'b0;
                        end
                        sap_pkg::OP_OUT: begin
                            ctrl_next.rega_en    = 1'b1;
                            ctrl_next.out_load_n = 1'b0;
                        end
                        sap_pkg::OP_JMP: begin
                            ctrl_next.ir_en_n = 1'b0;   // PC <= operand
                            ctrl_next.pc_load = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
            sap_pkg::T4: begin
                if (prog_sync) begin
                    ctrl_next.ram_load_n = 1'b0;
                    done_next            = 1'b1;
                end else begin
                    case (opcode)
                        sap_pkg::OP_ADD, sap_pkg::OP_SUB: begin
                            ctrl_next.ram_en_n    = 1'b0;
                            ctrl_next.regb_load_n = 1'b0;
                        end
                        sap_pkg::OP_LDA: begin
                            ctrl_next.ram_en_n    = 1'b0;
                            ctrl_next.rega_load_n = 1'b0;
                        end
                        sap_pkg::OP_STA: begin
                            ctrl_next.rega_en        = 1'b1;   // MDR <= A
                            ctrl_next.mar_mem_load_n = 1'b0;
                        end
                        default: ;
                    endcase
                end
            end
            sap_pkg::T5: begin
                if (!prog_sync) begin
                    case (opcode)
                        sap_pkg::OP_ADD, sap_pkg::OP_SUB: begin
                            ctrl_next.alu_sub     = (opcode == sap_pkg::OP_SUB);
                            ctrl_next.regb_en     = 1'b1;
                            ctrl_next.rega_load_n = 1'b0;
                        end
                        sap_pkg::OP_STA: ctrl_next.ram_load_n = 1'b0;
                        default: ;
                    endcase
                end
            end
            default: ;   // IDLE and HALT drive nothing
        endcase
    end

    // Decoded half a cycle ahead of the datapath edge
    always_ff @(negedge clk) begin
        if (!resetn) begin
            ctrl       <= sap_pkg::CTRL_IDLE;
            read_ui_in <= 1'b0;
            done_load  <= 1'b0;
            ready      <= 1'b0;
        end else begin
            ctrl       <= ctrl_next;
            read_ui_in <= read_next;
            done_load  <= done_next;
            ready      <= ready_next;
        end
    end

endmodule

`default_nettype wire

// ==== sap_datapath.sv ====
// ---------------------------------------------------------------------------
// SAP datapath
// Program counter, memory address and data registers, 16-word RAM,
// instruction register, accumulator A, operand register B and the
// adder-subtractor, all joined by one shared 8-bit bus
// ---------------------------------------------------------------------------
`default_nettype none

`include "sap_params.svh"

module sap_datapath (
    input  wire logic              clk,
    input  wire logic              resetn,
    input  wire sap_pkg::ctrl_t    ctrl,
    input  wire logic              read_ui_in,
    input  wire sap_pkg::data_t    in_byte,
    output sap_pkg::opcode_t       opcode,
    output sap_pkg::data_t         reg_a
);

    sap_pkg::addr_t pc;
    sap_pkg::addr_t mar;
    sap_pkg::data_t mdr;
    sap_pkg::data_t ir;
    sap_pkg::data_t reg_b;
    sap_pkg::data_t ram [`SAP_RAM_DEPTH];
    sap_pkg::data_t ram_rdata;
    sap_pkg::data_t alu_out;
    sap_pkg::data_t bus;

    assign ram_rdata = ram[mar];   // Asynchronous read
    assign alu_out   = ctrl.alu_sub ? reg_a - reg_b : reg_a + reg_b;

    // Bus source select, one enable is active at a time
    always_comb begin
        if (read_ui_in)
            bus = in_byte;
        else if (ctrl.pc_en)
            bus = sap_pkg::data_t'(pc);
        else if (!ctrl.ir_en_n)
            bus = sap_pkg::data_t'(ir[`SAP_ADDR_W-1:0]);
        else if (!ctrl.ram_en_n)
            bus = ram_rdata;
        else if (ctrl.rega_en)
            bus = reg_a;
        else if (ctrl.regb_en)
            bus = alu_out;
        else
            bus = '0;
    end

    // Program counter, jump wins over increment
    always_ff @(posedge clk) begin
        if (!resetn)
            pc <= '0;
        else if (ctrl.pc_load)
            pc <= bus[`SAP_ADDR_W-1:0];
        else if (ctrl.pc_inc)
            pc <= pc + 1'b1;
    end

    // Memory address and memory data registers
    always_ff @(posedge clk) begin
        if (!ctrl.mar_addr_load_n)
            mar <= bus[`SAP_ADDR_W-1:0];
        if (!ctrl.mar_mem_load_n)
            mdr <= bus;
    end

    always_ff @(posedge clk) begin
        if (!ctrl.ram_load_n)
            ram[mar] <= mdr;
    end

    // Instruction register, accumulator and operand register
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ir    <= '0;
            reg_a <= '0;
            reg_b <= '0;
        end else begin
            if (!ctrl.ir_load_n)
                ir <= bus;
            if (!ctrl.rega_load_n)
                reg_a <= bus;
            if (!ctrl.regb_load_n)
                reg_b <= bus;
        end
    end

    assign opcode = ir[`SAP_DATA_W-1:`SAP_ADDR_W];   // Upper nibble

endmodule

`default_nettype wire

// ==== sap_output.sv ====
// ---------------------------------------------------------------------------
// SAP output register
// Captures the accumulator on OUT and flags each load with a valid pulse
// ---------------------------------------------------------------------------
`default_nettype none

module sap_output (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            out_load_n,
    input  wire sap_pkg::data_t  reg_a,
    output sap_pkg::data_t       out_data,
    output logic                 out_valid
);

    always_ff @(posedge clk) begin
        if (!out_load_n)
            out_data <= reg_a;
    end

    // High for the one cycle after each load
    always_ff @(posedge clk) begin
        if (!resetn)
            out_valid <= 1'b0;
        else
            out_valid <= !out_load_n;
    end

endmodule

`default_nettype wire

// ==== sap_params.svh ====
// ---------------------------------------------------------------------------
// SAP accumulator computer parameters
// Data, address and memory sizes shared by the package and the datapath
// ---------------------------------------------------------------------------

`ifndef SAP_PARAMS_SVH
`define SAP_PARAMS_SVH

// Data bus and instruction word width
`define SAP_DATA_W 8

// Program counter and memory address width
`define SAP_ADDR_W 4

`define SAP_RAM_DEPTH 16   // Words of program and data memory

`endif

// ==== sap_pkg.sv ====
// ---------------------------------------------------------------------------
// SAP shared types
// Data and address types, opcodes, sequencer stages and the control word
// ---------------------------------------------------------------------------
`default_nettype none

`include "sap_params.svh"

package sap_pkg;

    typedef logic [`SAP_DATA_W-1:0] data_t;
    typedef logic [`SAP_ADDR_W-1:0] addr_t;
    typedef logic [3:0]             opcode_t;

    localparam opcode_t OP_HLT = 4'h0;
    localparam opcode_t OP_NOP = 4'h1;
    localparam opcode_t OP_ADD = 4'h2;
    localparam opcode_t OP_SUB = 4'h3;
    localparam opcode_t OP_LDA = 4'h4;
    localparam opcode_t OP_OUT = 4'h5;
    localparam opcode_t OP_STA = 4'h6;
    localparam opcode_t OP_JMP = 4'h7;

    typedef enum logic [2:0] {
        T0   = 3'd0,
        T1   = 3'd1,
        T2   = 3'd2,
        T3   = 3'd3,
        T4   = 3'd4,
        T5   = 3'd5,
        IDLE = 3'd6,   // Holding stage between passes
        HALT = 3'd7    // Parked until reset
    } stage_t;

    // Control word, MSB first; suffix _n marks an active low strobe
    typedef struct packed {
        logic pc_inc;
        logic pc_en;
        logic pc_load;
        logic mar_addr_load_n;
        logic mar_mem_load_n;
        logic ram_en_n;
        logic ram_load_n;
        logic ir_load_n;
        logic ir_en_n;
        logic rega_load_n;
        logic rega_en;
        logic alu_sub;
        logic regb_en;
        logic regb_load_n;
        logic out_load_n;
    } ctrl_t;

    localparam ctrl_t CTRL_IDLE = 15'b000_1111_1110_0011;   // Every strobe inactive

endpackage

`default_nettype wire

// ==== sap_prog_port.sv ====
// ---------------------------------------------------------------------------
// SAP input port
// Brings the asynchronous programming switch into the clock domain and
// registers the external byte so it is steady when the sequencer reads it
// ---------------------------------------------------------------------------
`default_nettype none

module sap_prog_port (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            programming,
    input  wire sap_pkg::data_t  ui_in,
    output logic                 prog_sync,
    output sap_pkg::data_t       in_byte
);

    logic prog_meta;   // First synchronizer stage
    logic prog_hold;   // Second synchronizer stage

    // Two-flop synchronizer for the switch level
    always_ff @(posedge clk) begin
        if (!resetn) begin
            prog_meta <= 1'b0;
            prog_hold <= 1'b0;
        end else begin
            prog_meta <= programming;
            prog_hold <= prog_meta;
        end
    end

    assign prog_sync = prog_hold;

    // Byte is sampled every cycle, so it has long settled by T3
    always_ff @(posedge clk) begin
        in_byte <= ui_in;
    end

endmodule

`default_nettype wire

// ==== sap_sva.sv ====
// ---------------------------------------------------------------------------
// SAP sequencer assertions
// Rules on ready, halt, programming strobes and the control word
// ---------------------------------------------------------------------------
`default_nettype none

module sap_sva (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            prog_sync,
    input  wire sap_pkg::ctrl_t  ctrl,
    input  wire logic            read_ui_in,
    input  wire logic            done_load,
    input  wire logic            ready,
    input  wire logic            halted
);

    // One T0 per seven-cycle pass
    ready_single: assert property (@(posedge clk) disable iff (!resetn)
        ready |=> !ready)
        else $error("ready high for two cycles in a row");

    halt_quiet: assert property (@(posedge clk) disable iff (!resetn)
        halted |=> ctrl == sap_pkg::CTRL_IDLE)
        else $error("control word active after halt");

    // Byte loading belongs to programming passes only
    load_in_prog: assert property (@(posedge clk) disable iff (!resetn)
        (read_ui_in || done_load) |-> prog_sync)
        else $error("read_ui_in or done_load outside programming");

    no_fetch_in_prog: assert property (@(posedge clk) disable iff (!resetn)
        prog_sync |-> ctrl.ir_load_n)
        else $error("instruction fetch during programming");

endmodule

bind sap_control sap_sva u_sva (
    .clk        (clk),
    .resetn     (resetn),
    .prog_sync  (prog_sync),
    .ctrl       (ctrl),
    .read_ui_in (read_ui_in),
    .done_load  (done_load),
    .ready      (ready),
    .halted     (halted)
);

`default_nettype wire

// ==== sap_top.sv ====
// ---------------------------------------------------------------------------
// SAP computer top level
// Input port, micro-sequencer, datapath and output register
// ---------------------------------------------------------------------------
`default_nettype none

module sap_top (
    input  wire logic            clk,
    input  wire logic            resetn,
    input  wire logic            programming,
    input  wire sap_pkg::data_t  ui_in,
    output sap_pkg::data_t       out_data,
    output logic                 out_valid,
    output logic                 done_load,
    output logic                 ready,
    output logic                 halted
);

    logic             prog_sync;
    sap_pkg::data_t   in_byte;
    sap_pkg::ctrl_t   ctrl;
    logic             read_ui_in;
    sap_pkg::opcode_t opcode;
    sap_pkg::data_t   reg_a;

    sap_prog_port u_prog_port (
        .clk         (clk),
        .resetn      (resetn),
        .programming (programming),
        .ui_in       (ui_in),
        .prog_sync   (prog_sync),
        .in_byte     (in_byte)
    );

    sap_control u_control (
        .clk        (clk),
        .resetn     (resetn),
        .opcode     (opcode),
        .prog_sync  (prog_sync),
        .ctrl       (ctrl),
        .read_ui_in (read_ui_in),
        .done_load  (done_load),
        .ready      (ready),
        .halted     (halted)
    );

    sap_datapath u_datapath (
        .clk        (clk),
        .resetn     (resetn),
        .ctrl       (ctrl),
        .read_ui_in (read_ui_in),
        .in_byte    (in_byte),
        .opcode     (opcode),
        .reg_a      (reg_a)
    );

    sap_output u_output (
        .clk        (clk),
        .resetn     (resetn),
        .out_load_n (ctrl.out_load_n),   // Only the OUT strobe leaves the core
        .reg_a      (reg_a),
        .out_data   (out_data),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// ==== tb_sap.sv ====
// ---------------------------------------------------------------------------
// SAP computer testbench
// Loads random programs through the programming port, runs them and
// checks the output stream against an instruction-level model
// ---------------------------------------------------------------------------
`default_nettype none

`include "sap_params.svh"

module tb_sap;

    localparam int NUM_PROGS  = 20;
    localparam int MAX_CYCLES = 8000;   // 20 programs of about 250 cycles, with margin

    logic           clk;
    logic           resetn;
    logic           programming;
    sap_pkg::data_t ui_in;
    sap_pkg::data_t out_data;
    logic           out_valid;
    logic           done_load;
    logic           ready;
    logic           halted;

    logic [31:0]    rng;
    sap_pkg::data_t prog [`SAP_RAM_DEPTH];
    sap_pkg::data_t exp_out [$];
    int             model_steps;
    int             run_errors;

    // Written only by the sampling process
    sap_pkg::data_t got_out [$];
    int             mon_errors = 0;
    int             cycle = 0;
    int             since_rst;
    int             done_cnt;
    int             last_done;
    int             ready_cnt;
    logic           halt_seen;

    sap_top u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .programming (programming),
        .ui_in       (ui_in),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .done_load   (done_load),
        .ready       (ready),
        .halted      (halted)
    );

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            mon_errors++;
            $display("** Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    always @(posedge clk) begin
        #10;   // Quarter period after the edge, all outputs settled
        cycle = cycle + 1;
        if (cycle > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end else if (!resetn) begin
            since_rst = 0;
            done_cnt  = 0;
            ready_cnt = 0;
            halt_seen = 1'b0;
            got_out.delete();
        end else begin
            since_rst = since_rst + 1;
            if (since_rst <= 2) begin   // Reset state, then the IDLE cycle
                check_bit("out_valid", out_valid, 1'b0);
                check_bit("done_load", done_load, 1'b0);
                check_bit("halted", halted, 1'b0);
                check_bit("ready", ready, 1'b0);
            end
            if (since_rst == 3)
                check_bit("ready", ready, 1'b1);   // T0 of the first pass
            if (done_load) begin
                if (done_cnt > 0) begin
                    assert (cycle - last_done == 7) else begin
                        mon_errors++;
                        $display("done_load came %0d cycles after the previous one, not 7",
                                 cycle - last_done);
                    end
                end
                done_cnt++;
                last_done = cycle;
            end
            assert (!(halted && (ready || out_valid))) else begin
                mon_errors++;
                $display("ready or out_valid pulsed at %0t after the DUT halted", $time);
            end
            if (ready)
                ready_cnt++;
            if (out_valid)
                got_out.push_back(out_data);
            halt_seen = halted;
        end
    end

    // Code in words 0 to 9, data in 10 to 15
    task automatic make_program(input int p);
        int t;
        for (int i = 0; i < `SAP_RAM_DEPTH; i++) begin
            rng     = xorshift(rng);
            prog[i] = rng[7:0];
        end
        for (int i = 0; i < 9; i++) begin
            rng = xorshift(rng);
            t   = i + 1 + int'(rng[15:8]) % (9 - i);   // Forward only
            case (rng[3:0])
                4'd0, 4'd1, 4'd2: prog[i] = {sap_pkg::OP_ADD, rng[7:4]};
                4'd3, 4'd4:       prog[i] = {sap_pkg::OP_SUB, rng[7:4]};
                4'd5, 4'd6:       prog[i] = {sap_pkg::OP_LDA, rng[7:4]};
                4'd7, 4'd8, 4'd9: prog[i] = {sap_pkg::OP_OUT, rng[7:4]};
                4'd10, 4'd11:     prog[i] = {sap_pkg::OP_STA, 4'd10 + rng[7:4] % 4'd6};
                4'd12:            prog[i] = {sap_pkg::OP_JMP, 4'(t)};
                4'd13:            prog[i] = {sap_pkg::OP_NOP, rng[7:4]};
                default:          prog[i] = {1'b1, rng[18:16], rng[7:4]};   // Opcodes 8 to 15
            endcase
        end
        prog[9] = {sap_pkg::OP_HLT, rng[23:20]};
        if (p == 0) begin   // Readback of data words and one code word
            prog[0] = {sap_pkg::OP_LDA, 4'd10};
            prog[1] = {sap_pkg::OP_OUT, 4'd0};
            prog[2] = {sap_pkg::OP_LDA, 4'd13};
            prog[3] = {sap_pkg::OP_OUT, 4'd0};
            prog[4] = {sap_pkg::OP_LDA, 4'd15};
            prog[5] = {sap_pkg::OP_OUT, 4'd0};
            prog[6] = {sap_pkg::OP_LDA, 4'd3};
            prog[7] = {sap_pkg::OP_OUT, 4'd0};
            prog[8] = {sap_pkg::OP_HLT, 4'd0};
        end
    endtask

    task automatic run_model();
        sap_pkg::data_t   mem [`SAP_RAM_DEPTH];
        sap_pkg::data_t   acc;
        sap_pkg::data_t   instr;
        sap_pkg::addr_t   pc;
        sap_pkg::opcode_t op;
        sap_pkg::addr_t   opd;
        logic             running;
        for (int i = 0; i < `SAP_RAM_DEPTH; i++)
            mem[i] = prog[i];
        acc         = '0;
        pc          = '0;
        running     = 1'b1;
        model_steps = 0;
        exp_out.delete();
        while (running) begin
            instr = mem[pc];
            op    = instr[7:4];
            opd   = instr[3:0];
            pc    = pc + 4'd1;
            model_steps++;
            case (op)
                sap_pkg::OP_HLT: running = 1'b0;
                sap_pkg::OP_ADD: acc = acc + mem[opd];   // 8-bit wraparound
                sap_pkg::OP_SUB: acc = acc - mem[opd];
                sap_pkg::OP_LDA: acc = mem[opd];
                sap_pkg::OP_OUT: exp_out.push_back(acc);
                sap_pkg::OP_STA: mem[opd] = acc;
                sap_pkg::OP_JMP: pc = opd;
                default: ;
            endcase
        end
    endtask

    task automatic load_program();
        @(posedge clk);
        resetn      <= 1'b0;
        programming <= 1'b1;
        ui_in       <= prog[0];
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        for (int k = 0; k < `SAP_RAM_DEPTH; k++) begin
            while (done_cnt <= k)
                @(posedge clk);
            if (k < `SAP_RAM_DEPTH - 1)
                ui_in <= prog[k+1];   // Well before the next T3
        end
    endtask

    task automatic run_program();
        // Last done_load falls in T4 of the 16th pass, seven cycles per pass
        assert (since_rst == 7 * `SAP_RAM_DEPTH) else begin
            run_errors++;
            $display("** Error at %0t: since_rst = %0d at the last done_load, expected %0d",
                     $time, since_rst, 7 * `SAP_RAM_DEPTH);
        end
        resetn      <= 1'b0;   // Also ends programming before a 17th pass writes
        programming <= 1'b0;
        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        while (!halt_seen)
            @(posedge clk);
        repeat (14) @(posedge clk);   // Two more passes must stay quiet
    endtask

    task automatic compare_results(input int p);
        assert (got_out.size() == exp_out.size()) else begin
            run_errors++;
            $display("** Error at %0t: out_valid count = %0d, expected %0d in program %0d",
                     $time, got_out.size(), exp_out.size(), p);
        end
        for (int i = 0; i < got_out.size() && i < exp_out.size(); i++) begin
            assert (got_out[i] == exp_out[i]) else begin
                run_errors++;
                $display("** Error at %0t: out_data #%0d = %h, expected %h in program %0d",
                         $time, i, got_out[i], exp_out[i], p);
            end
        end
        assert (ready_cnt == model_steps) else begin
            run_errors++;
            $display("** Error at %0t: ready count = %0d, expected %0d in program %0d",
                     $time, ready_cnt, model_steps, p);
        end
        assert (done_cnt == 0) else begin
            run_errors++;
            $display("** Error at %0t: done_load count = %0d, expected 0 while running",
                     $time, done_cnt);
        end
    endtask

    initial begin
        clk         = 1'b0;
        resetn      = 1'b0;
        programming = 1'b0;
        ui_in       = '0;
        rng         = 32'h3d4d_ef55;
        run_errors  = 0;
        for (int p = 0; p < NUM_PROGS; p++) begin
            make_program(p);
            run_model();
            load_program();
            run_program();
            compare_results(p);
        end
        $display("Errors: %0d in cycle checks, %0d in program checks", mon_errors, run_errors);
        if (mon_errors + run_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire
